/* tests/exec_testdata.txt */
// op cond a b tag | expected result, flags {c,o,s,z}, executed
// hex fields; vector k runs on lane k mod 4
0 0 00000000ffffffff 0000000000000001 00 0000000100000000 0 1
1 0 0000000000000010 0000000000000003 01 000000000000000d 8 1
2 0 ff00ff00ff00ff00 0f0f0f0f0f0f0f0f 02 0f000f000f000f00 0 1
3 0 aaaaaaaaaaaaaaaa 5555555555555555 03 ffffffffffffffff 2 1
4 0 8000000000000000 0000000000000001 04 8000000000000001 2 1
8 0 0000000000001234 0123456789abcdef 05 0123456789abcdef 0 1
0 0 ffffffffffffffff 0000000000000001 06 0000000000000000 9 1
0 0 7fffffffffffffff 0000000000000001 07 8000000000000000 6 1
1 0 8000000000000000 0000000000000001 08 7fffffffffffffff c 1
1 0 0000000000000005 0000000000000005 09 0000000000000000 9 1
1 0 0000000000000003 0000000000000005 0a fffffffffffffffe 2 1
0 0 0000000080000000 0000000080000000 0b 0000000100000000 0 1
5 0 0123456789abcdef 0000000000000000 0c 0123456789abcdef 0 1
5 0 0000000000000001 000000000000001f 0d 0000000080000000 0 1
5 0 0000000000000001 0000000000000020 0e 0000000100000000 0 1
5 0 0000000000000003 000000000000003f 0f 8000000000000000 2 1
6 0 8000000000000000 000000000000003f 10 0000000000000001 0 1
6 0 f000000000000000 0000000000000020 11 00000000f0000000 0 1
7 0 8000000000000000 000000000000001f 12 ffffffff00000000 2 1
7 0 8000000000000000 000000000000003f 13 ffffffffffffffff 2 1
0 3 ffffffffffffffff 0000000000000001 14 0000000000000000 9 1
0 7 7fffffffffffffff 0000000000000001 15 8000000000000000 6 1
1 6 0000000000000003 0000000000000005 16 fffffffffffffffe 2 1
1 d 0000000000000010 0000000000000003 17 000000000000000d 8 1
0 1 0000000000000001 0000000000000001 18 0000000000000000 9 0
1 9 0000000000000009 0000000000000001 19 0000000000000000 6 0
2 c ffffffffffffffff ffffffffffffffff 1a 0000000000000000 2 0
4 b 0000000000000000 0000000000000000 1b 0000000000000000 8 0
5 a 0000000000000001 0000000000000004 1c 0000000000000000 9 0
8 4 0000000000000000 1111111111111111 1d 0000000000000000 6 0
3 2 00000000000000ff 0000000000000000 1e 0000000000000000 2 0
0 5 ffffffffffffffff 0000000000000001 1f 0000000000000000 8 0
8 f 00000000000000ff 0000000000000000 20 0000000000000000 1 1
2 8 000000000000ff00 0000000000000ff0 21 0000000000000f00 0 1
0 e 0000000000000001 0000000000000001 22 0000000000000000 2 0
3 a 000000000000000f 00000000000000ff 23 00000000000000f0 0 1

/* vlog.f */
src/exec_pkg.sv
src/exec_if.sv
src/issue_dispatch.sv
src/alu_lane.sv
src/wb_collect.sv
src/exec_cluster.sv
tests/exec_checker.sv
tests/exec_monitor.sv
tests/tb_exec_cluster.sv

/* Makefile */
# Verilator build and run of the exec_cluster testbench

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check the log"
	@echo "make clean  remove the build output and the log"
	@echo "make help   list these targets"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_exec_cluster -Mdir obj_dir -f vlog.f
	./obj_dir/Vtb_exec_cluster | tee sim.log
	grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* tests/tb_exec_cluster.sv */
// testbench top with clock, reset, file-driven stimulus, timeout
// and the exec_cluster instance with its monitor
module tb_exec_cluster;
  timeunit 1ns;
  timeprecision 1ps;
  import exec_pkg::*;

  localparam int BURST = 8;  // last vectors go back to back

  logic clk;
  logic rst;
  logic in_valid;
  op_e in_op;
  cond_e in_cond;
  logic [XLEN-1:0] in_a;
  logic [XLEN-1:0] in_b;
  logic [TAG_W-1:0] in_tag;
  logic out_valid;
  logic [TAG_W-1:0] out_tag;
  logic [XLEN-1:0] out_result;
  flags_t out_flags;
  logic out_executed;

  int checked;
  int errors;
  int num_vec = 0;
  int cycles = 0;

  logic [3:0] vec_op [$];
  logic [3:0] vec_cond [$];
  logic [XLEN-1:0] vec_a [$];
  logic [XLEN-1:0] vec_b [$];
  logic [TAG_W-1:0] vec_tag [$];

  exec_cluster u_exec_cluster (
    .clk(clk),
    .rst(rst),
    .in_valid(in_valid),
    .in_op(in_op),
    .in_cond(in_cond),
    .in_a(in_a),
    .in_b(in_b),
    .in_tag(in_tag),
    .out_valid(out_valid),
    .out_tag(out_tag),
    .out_result(out_result),
    .out_flags(out_flags),
    .out_executed(out_executed)
  );

  exec_monitor u_exec_monitor (
    .clk(clk),
    .rst(rst),
    .out_valid(out_valid),
    .out_tag(out_tag),
    .out_result(out_result),
    .out_flags(out_flags),
    .out_executed(out_executed),
    .checked(checked),
    .errors(errors)
  );

  task automatic load_vectors();
    int fd;
    string line;
    logic [63:0] f_op, f_cond, f_a, f_b, f_tag, f_res, f_flags, f_exec;
    fd = $fopen("tests/exec_testdata.txt", "r");
    if (fd == 0) begin
      $display("cannot open tests/exec_testdata.txt");
      return;
    end
    while ($fgets(line, fd) != 0) begin
      if ($sscanf(line, "%h %h %h %h %h %h %h %h", f_op, f_cond, f_a, f_b, f_tag,
                  f_res, f_flags, f_exec) == 8) begin
        vec_op.push_back(f_op[3:0]);
        vec_cond.push_back(f_cond[3:0]);
        vec_a.push_back(f_a);
        vec_b.push_back(f_b);
        vec_tag.push_back(f_tag[TAG_W-1:0]);
      end
    end
    $fclose(fd);
    num_vec = vec_tag.size();
  endtask

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // one result per vector plus room for idle cycles and pipeline drain
  always @(posedge clk) begin
    cycles++;
    if (cycles > 4 * num_vec + 40) begin
      $display("timeout: %0d of %0d results arrived", checked, num_vec);
      $display("tests failed");
      $finish;
    end
  end

  initial begin
    int idle;
    void'($urandom(32'h22f1));
    rst = 1'b1;
    in_valid = 1'b0;
    in_op = OP_ADD;
    in_cond = COND_AL;
    in_a = '0;
    in_b = '0;
    in_tag = '0;
    load_vectors();
    repeat (5) @(posedge clk);
    #1 rst = 1'b0;
    for (int i = 0; i < num_vec; i++) begin
      idle = (i < num_vec - BURST) ? $urandom_range(2, 0) : 0;
      repeat (idle) begin
        @(posedge clk);
        #1 in_valid = 1'b0;
      end
      @(posedge clk);
      #1;
      in_valid = 1'b1;
      in_op = op_e'(vec_op[i]);
      in_cond = cond_e'(vec_cond[i]);
      in_a = vec_a[i];
      in_b = vec_b[i];
      in_tag = vec_tag[i];
    end
    @(posedge clk);
    #1 in_valid = 1'b0;
    wait (checked == num_vec);
    repeat (3) @(posedge clk);  // catch stray results
    $display("results checked: %0d of %0d, errors: %0d, assertion failures: %0d",
             checked, num_vec, errors, u_exec_cluster.u_exec_checker.fail_count);
    if (errors == 0 && checked == num_vec && num_vec > 0 &&
        u_exec_cluster.u_exec_checker.fail_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* tests/exec_monitor.sv */
// output monitor that loads expected results, compares each out_valid
// beat in issue order and counts mismatches
module exec_monitor (
  input logic clk,
  input logic rst,
  input logic out_valid,
  input logic [exec_pkg::TAG_W-1:0] out_tag,
  input logic [exec_pkg::XLEN-1:0] out_result,
  input exec_pkg::flags_t out_flags,
  input logic out_executed,
  output int checked,
  output int errors
);
  timeunit 1ns;
  timeprecision 1ps;
  import exec_pkg::*;

  logic [TAG_W-1:0] exp_tag [$];
  logic [XLEN-1:0] exp_result [$];
  logic [3:0] exp_flags [$];
  logic exp_exec [$];

  int n_checked = 0;
  int n_errors = 0;

  assign checked = n_checked;
  assign errors = n_errors;

  task automatic load_expected();
    int fd;
    string line;
    logic [63:0] f_op, f_cond, f_a, f_b, f_tag, f_res, f_flags, f_exec;
    fd = $fopen("tests/exec_testdata.txt", "r");
    if (fd == 0) begin
      $display("monitor cannot open tests/exec_testdata.txt");
      return;
    end
    while ($fgets(line, fd) != 0) begin
      if ($sscanf(line, "%h %h %h %h %h %h %h %h", f_op, f_cond, f_a, f_b, f_tag,
                  f_res, f_flags, f_exec) == 8) begin
        exp_tag.push_back(f_tag[TAG_W-1:0]);
        exp_result.push_back(f_res);
        exp_flags.push_back(f_flags[3:0]);
        exp_exec.push_back(f_exec[0]);
      end
    end
    $fclose(fd);
  endtask

  task automatic compare_value(string name, logic [63:0] got, logic [63:0] exp);
    if (got !== exp) begin
      n_errors++;
      $display("Fail %s (result %0d): got %0h, expected %0h", name, n_checked, got, exp);
    end
  endtask

  initial load_expected();

  // outputs are registered, so the falling edge sees them settled
  always @(negedge clk) begin
    if (!rst && out_valid) begin
      if (n_checked >= exp_tag.size()) begin
        n_errors++;
        $display("unexpected result with tag %0h after the last expected one", out_tag);
      end else begin
        compare_value("out_tag", 64'(out_tag), 64'(exp_tag[n_checked]));
        compare_value("out_result", out_result, exp_result[n_checked]);
        compare_value("out_flags", 64'(out_flags), 64'(exp_flags[n_checked]));
        compare_value("out_executed", 64'(out_executed), 64'(exp_exec[n_checked]));
        n_checked++;
      end
    end
  end

endmodule

/* tests/exec_checker.sv */
// timing assertions on the cluster outputs bound into exec_cluster
module exec_checker (
  input logic clk,
  input logic rst,
  input logic in_valid,
  input logic out_valid,
  input logic [exec_pkg::XLEN-1:0] out_result,
  input logic out_executed
);
  timeunit 1ns;
  timeprecision 1ps;

  int fail_count = 0;

  // fixed four cycle latency in both directions
  a_latency: assert property (@(posedge clk) disable iff (rst)
    out_valid == $past(in_valid, 4))
    else begin
      fail_count++;
      $error("out_valid does not follow in_valid by four cycles");
    end

  a_reset_idle: assert property (@(posedge clk) rst && $past(rst) |-> !out_valid)
    else begin
      fail_count++;
      $error("out_valid high during reset");
    end

  a_skip_zero: assert property (@(posedge clk) disable iff (rst)
    !out_executed |-> out_result == '0)
    else begin
      fail_count++;
      $error("out_result nonzero while out_executed is low");
    end

endmodule

bind exec_cluster exec_checker u_exec_checker (
  .clk(clk),
  .rst(rst),
  .in_valid(in_valid),
  .out_valid(out_valid),
  .out_result(out_result),
  .out_executed(out_executed)
);

/* src/exec_cluster.sv */
// execution cluster top with dispatcher, ALU lanes and writeback collector
module exec_cluster #(
  parameter int NUM_LANES = 4  // at least 2
) (
  input logic clk,
  input logic rst,
  input logic in_valid,
  input exec_pkg::op_e in_op,
  input exec_pkg::cond_e in_cond,
  input logic [exec_pkg::XLEN-1:0] in_a,
  input logic [exec_pkg::XLEN-1:0] in_b,
  input logic [exec_pkg::TAG_W-1:0] in_tag,
  output logic out_valid,
  output logic [exec_pkg::TAG_W-1:0] out_tag,
  output logic [exec_pkg::XLEN-1:0] out_result,
  output exec_pkg::flags_t out_flags,
  output logic out_executed
);

  issue_if iss_bus [NUM_LANES] ();
  result_if res_bus [NUM_LANES] ();

  issue_dispatch #(
    .NUM_LANES(NUM_LANES)
  ) u_issue_dispatch (
    .clk(clk),
    .rst(rst),
    .in_valid(in_valid),
    .in_op(in_op),
    .in_cond(in_cond),
    .in_a(in_a),
    .in_b(in_b),
    .in_tag(in_tag),
    .lanes(iss_bus)
  );

  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    alu_lane u_alu_lane (
      .clk(clk),
      .rst(rst),
      .iss(iss_bus[i]),
      .res(res_bus[i])
    );
  end

  wb_collect #(
    .NUM_LANES(NUM_LANES)
  ) u_wb_collect (
    .clk(clk),
    .rst(rst),
    .lanes(res_bus),
    .out_valid(out_valid),
    .out_tag(out_tag),
    .out_result(out_result),
    .out_flags(out_flags),
    .out_executed(out_executed)
  );

endmodule

/* src/wb_collect.sv */
// writeback stage that picks the one finishing lane and registers the outputs
module wb_collect #(
  parameter int NUM_LANES = 4
) (
  input logic clk,
  input logic rst,
  result_if.sink lanes [NUM_LANES],
  output logic out_valid,
  output logic [exec_pkg::TAG_W-1:0] out_tag,
  output logic [exec_pkg::XLEN-1:0] out_result,
  output exec_pkg::flags_t out_flags,
  output logic out_executed
);
  import exec_pkg::*;

  logic [NUM_LANES-1:0] valid_v;
  logic [TAG_W-1:0] tag_v [NUM_LANES];
  logic [XLEN-1:0] result_v [NUM_LANES];
  flags_t flags_v [NUM_LANES];
  logic [NUM_LANES-1:0] exec_v;

  logic [TAG_W-1:0] sel_tag;
  logic [XLEN-1:0] sel_result;
  flags_t sel_flags;
  logic sel_exec;

  for (genvar i = 0; i < NUM_LANES; i++) begin : g_unpack
    assign valid_v[i] = lanes[i].valid;
    assign tag_v[i] = lanes[i].tag;
    assign result_v[i] = lanes[i].result;
    assign flags_v[i] = lanes[i].flags;
    assign exec_v[i] = lanes[i].executed;
  end

  // fixed latency, so at most one lane is valid
  always_comb begin
    sel_tag = '0;
    sel_result = '0;
    sel_flags = '0;
    sel_exec = 1'b0;
    for (int i = 0; i < NUM_LANES; i++) begin
      if (valid_v[i]) begin
        sel_tag = tag_v[i];
        sel_result = result_v[i];
        sel_flags = flags_v[i];
        sel_exec = exec_v[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= |valid_v;
    end
  end

  always_ff @(posedge clk) begin
    out_tag <= sel_tag;
    out_result <= sel_result;  // zero on idle cycles
    out_flags <= sel_flags;
    out_executed <= sel_exec;
  end

endmodule

/* src/alu_lane.sv */
// predicated two-stage integer lane that adds the low half before the high half
// and keeps its own flag register
module alu_lane (
  input logic clk,
  input logic rst,
  issue_if.sink iss,
  result_if.source res
);
  import exec_pkg::*;

  // stage 1 registers
  logic s1_valid;
  logic s1_exec;
  op_e s1_op;
  logic [XLEN-1:0] s1_a;
  logic [XLEN-1:0] s1_b;
  logic [TAG_W-1:0] s1_tag;
  logic [HALF-1:0] s1_lo;
  logic s1_carry;

  flags_t flags_q;

  // stage 1 low half
  logic sub_in;
  logic [HALF-1:0] b_lo;
  logic [HALF:0] sum_lo;

  // stage 2
  logic [HALF-1:0] b_hi;
  logic [HALF:0] sum_hi;
  logic [XLEN-1:0] sum_full;
  logic [XLEN-1:0] alu_out;
  logic arith;
  flags_t flags_new;

  assign sub_in = (iss.op == OP_SUB);
  assign b_lo = sub_in ? ~iss.b[HALF-1:0] : iss.b[HALF-1:0];  // sub is a + ~b + 1
  assign sum_lo = {1'b0, iss.a[HALF-1:0]} + {1'b0, b_lo} + {{HALF{1'b0}}, sub_in};

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= iss.valid;
    end
  end

  always_ff @(posedge clk) begin
    s1_op <= iss.op;
    s1_a <= iss.a;
    s1_b <= iss.b;
    s1_tag <= iss.tag;
    s1_lo <= sum_lo[HALF-1:0];
    s1_carry <= sum_lo[HALF];
    s1_exec <= cond_holds(iss.cond, flags_q);  // flags of the previous op here
  end

  // high half picks up the registered carry
  assign b_hi = (s1_op == OP_SUB) ? ~s1_b[XLEN-1:HALF] : s1_b[XLEN-1:HALF];
  assign sum_hi = {1'b0, s1_a[XLEN-1:HALF]} + {1'b0, b_hi} + {{HALF{1'b0}}, s1_carry};
  assign sum_full = {sum_hi[HALF-1:0], s1_lo};
  assign arith = (s1_op == OP_ADD) || (s1_op == OP_SUB);

  always_comb begin
    case (s1_op)
      OP_ADD, OP_SUB: alu_out = sum_full;
      OP_AND: alu_out = s1_a & s1_b;
      OP_XOR: alu_out = s1_a ^ s1_b;
      OP_OR: alu_out = s1_a | s1_b;
      OP_SHL: alu_out = s1_a << s1_b[5:0];
      OP_SHR: alu_out = s1_a >> s1_b[5:0];
      OP_SAR: alu_out = XLEN'($signed(s1_a) >>> s1_b[5:0]);
      OP_MOV: alu_out = s1_b;
      default: alu_out = '0;
    endcase
  end

  always_comb begin
    flags_new.z = (alu_out == '0);
    flags_new.s = alu_out[XLEN-1];
    flags_new.c = arith & sum_hi[HALF];
    // result sign differs from two operands of equal sign
    flags_new.o = arith & (s1_a[XLEN-1] == b_hi[HALF-1]) &
                  (sum_full[XLEN-1] != s1_a[XLEN-1]);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      flags_q <= '0;
    end else if (s1_valid && s1_exec) begin
      flags_q <= flags_new;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      res.valid <= 1'b0;
    end else begin
      res.valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    res.tag <= s1_tag;
    res.executed <= s1_exec;
    res.result <= s1_exec ? alu_out : '0;
  end

  // held or freshly updated flags of this lane
  assign res.flags = flags_q;

endmodule

/* src/issue_dispatch.sv */
// round-robin issue stage with one registered slot per lane
module issue_dispatch #(
  parameter int NUM_LANES = 4
) (
  input logic clk,
  input logic rst,
  input logic in_valid,
  input exec_pkg::op_e in_op,
  input exec_pkg::cond_e in_cond,
  input logic [exec_pkg::XLEN-1:0] in_a,
  input logic [exec_pkg::XLEN-1:0] in_b,
  input logic [exec_pkg::TAG_W-1:0] in_tag,
  issue_if.source lanes [NUM_LANES]
);
  localparam int PTR_W = $clog2(NUM_LANES);
  localparam logic [PTR_W-1:0] LAST = PTR_W'(NUM_LANES - 1);

  logic [PTR_W-1:0] ptr;

  // advances only on accepted ops
  always_ff @(posedge clk) begin
    if (rst) begin
      ptr <= '0;
    end else if (in_valid) begin
      ptr <= (ptr == LAST) ? '0 : ptr + 1'b1;
    end
  end

  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    logic hit;

    assign hit = in_valid && (ptr == PTR_W'(i));

    always_ff @(posedge clk) begin
      if (rst) begin
        lanes[i].valid <= 1'b0;
      end else begin
        lanes[i].valid <= hit;  // other lanes see a low strobe
      end
    end

    always_ff @(posedge clk) begin
      if (hit) begin
        lanes[i].op <= in_op;
        lanes[i].cond <= in_cond;
        lanes[i].a <= in_a;
        lanes[i].b <= in_b;
        lanes[i].tag <= in_tag;
      end
    end
  end

endmodule

/* src/exec_if.sv */
// issue and result interfaces between dispatcher, lanes and collector

interface issue_if;
  import exec_pkg::*;

  logic valid;  // one-cycle strobe
  op_e op;
  cond_e cond;
  logic [XLEN-1:0] a;
  logic [XLEN-1:0] b;
  logic [TAG_W-1:0] tag;

  modport source (output valid, op, cond, a, b, tag);
  modport sink (input valid, op, cond, a, b, tag);
endinterface

interface result_if;
  import exec_pkg::*;

  logic valid;
  logic [TAG_W-1:0] tag;
  logic [XLEN-1:0] result;
  flags_t flags;
  logic executed;  // low when predicated off

  modport source (output valid, tag, result, flags, executed);
  modport sink (input valid, tag, result, flags, executed);
endinterface

/* src/exec_pkg.sv */
// shared widths, opcode and condition enums, flags struct
// and the condition evaluation function
package exec_pkg;

  localparam int XLEN  = 64;
  localparam int HALF  = 32;  // one pipeline half
  localparam int TAG_W = 8;

  typedef enum logic [3:0] {
    OP_ADD = 4'd0,
    OP_SUB = 4'd1,
    OP_AND = 4'd2,
    OP_XOR = 4'd3,
    OP_OR  = 4'd4,
    OP_SHL = 4'd5,
    OP_SHR = 4'd6,
    OP_SAR = 4'd7,
    OP_MOV = 4'd8
  } op_e;

  typedef enum logic [3:0] {
    COND_AL, COND_NV, COND_EQ, COND_NE,
    COND_CS, COND_CC, COND_MI, COND_PL,
    COND_VS, COND_VC, COND_HI, COND_LS,
    COND_GE, COND_LT, COND_GT, COND_LE
  } cond_e;

  typedef struct packed {
    logic c;  // carry out of bit 63
    logic o;  // signed overflow
    logic s;
    logic z;
  } flags_t;

  function automatic logic cond_holds(cond_e cond, flags_t f);
    logic hi;
    logic ge;
    logic gt;
    logic holds;
    hi = f.c & ~f.z;
    ge = (f.s == f.o);
    gt = ~f.z & ge;
    case (cond)
      COND_AL: holds = 1'b1;
      COND_NV: holds = 1'b0;
      COND_EQ: holds = f.z;
      COND_NE: holds = ~f.z;
      COND_CS: holds = f.c;
      COND_CC: holds = ~f.c;
      COND_MI: holds = f.s;
      COND_PL: holds = ~f.s;
      COND_VS: holds = f.o;
      COND_VC: holds = ~f.o;
      COND_HI: holds = hi;
      COND_LS: holds = ~hi;
      COND_GE: holds = ge;
      COND_LT: holds = ~ge;
      COND_GT: holds = gt;
      default: holds = ~gt;  // LE
    endcase
    return holds;
  endfunction

endpackage
